//--- source/mazePkg.sv
`default_nettype none

package mazePkg;

    // sensor vector, left / middle / right
    typedef logic [2:0] roadPattern;

    localparam roadPattern ROAD_LOST       = 3'b000;
    localparam roadPattern ROAD_STRAIGHT   = 3'b010;
    localparam roadPattern ROAD_JUNCTION   = 3'b111;
    localparam roadPattern ROAD_TEE        = 3'b101;
    localparam roadPattern ROAD_LEFT_HARD  = 3'b110;
    localparam roadPattern ROAD_LEFT_SOFT  = 3'b100;
    localparam roadPattern ROAD_RIGHT_HARD = 3'b011;
    localparam roadPattern ROAD_RIGHT_SOFT = 3'b001;

    typedef enum logic [1:0] {
        DEC_NONE,
        DEC_STRAIGHT,
        DEC_LEFT,
        DEC_RIGHT
    } decision;

    typedef enum logic [2:0] {
        MOTOR_STOP,
        MOTOR_FORWARD,
        MOTOR_VEER_LEFT,
        MOTOR_VEER_RIGHT,
        MOTOR_TURN_LEFT,
        MOTOR_TURN_RIGHT,
        MOTOR_REVERSE
    } motorCmd;

    typedef enum logic [2:0] {
        NAV_IDLE,
        NAV_FOLLOW,
        NAV_PAUSE,
        NAV_TURN_LEFT,
        NAV_TURN_RIGHT,
        NAV_BACK,
        NAV_DONE
    } navState;

    // junction decisions kept at most
    localparam int STACK_DEPTH = 50;
    typedef logic [5:0] stackIndex;

    // also the sampler's starting credit
    localparam int FIFO_DEPTH = 4;
    typedef logic [2:0] creditCount;

    localparam int FILTER_LEN = 4;

    // stop time before each manoeuvre
    localparam int PAUSE_CYCLES = 16;
    typedef logic [4:0] pauseCount;

endpackage

`default_nettype wire

//--- source/trackSampler.sv
`default_nettype none

module trackSampler (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire mazePkg::roadPattern sensors,
    input  wire logic                creditReturn,
    output logic                     patValid,
    output mazePkg::roadPattern      patData
);
    import mazePkg::*;

    typedef logic [$clog2(FILTER_LEN + 1)-1:0] runCount;

    roadPattern lastSample;
    runCount    runLen;
    logic       pendValid;
    roadPattern pendPat;
    logic       haveSent;
    roadPattern lastSent;
    creditCount credits;

    logic       newStable;
    logic       haveCand;
    roadPattern candidate;
    logic       isNew;
    logic       send;

    // run reaches FILTER_LEN equal samples on this one
    assign newStable = (sensors == lastSample) && (runLen == runCount'(FILTER_LEN - 1));

    always_comb begin
        haveCand  = newStable || pendValid;
        // a fresh stable pattern beats the pending one
        candidate = newStable ? sensors : pendPat;
        isNew     = !haveSent || (candidate != lastSent);
        send      = haveCand && isNew && (credits != '0);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lastSample <= ROAD_LOST;
            runLen     <= '0;
            pendValid  <= 1'b0;
            haveSent   <= 1'b0;
            patValid   <= 1'b0;
            credits    <= creditCount'(FIFO_DEPTH);
        end else begin
            lastSample <= sensors;
            if (sensors != lastSample) begin
                runLen <= runCount'(1);
            end else if (runLen != runCount'(FILTER_LEN)) begin
                runLen <= runLen + 1'b1;
            end

            patValid <= send;
            if (send) begin
                haveSent  <= 1'b1;
                pendValid <= 1'b0;
            end else if (haveCand && isNew) begin
                pendValid <= 1'b1;
            end else if (newStable) begin
                // latest stable road is the one already sent
                pendValid <= 1'b0;
            end

            credits <= credits - creditCount'(send) + creditCount'(creditReturn);
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            patData  <= candidate;
            lastSent <= candidate;
        end else if (haveCand && isNew) begin
            pendPat <= candidate;
        end
    end

endmodule

`default_nettype wire

//--- source/patternFifo.sv
`default_nettype none

module patternFifo (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                patValid,
    input  wire mazePkg::roadPattern patData,
    input  wire logic                take,
    output logic                     notEmpty,
    output mazePkg::roadPattern      headPattern,
    output logic                     creditReturn
);
    import mazePkg::*;

    typedef logic [$clog2(FIFO_DEPTH)-1:0] fifoPtr;

    roadPattern slots [FIFO_DEPTH];
    fifoPtr     wrPtr;
    fifoPtr     rdPtr;
    creditCount fill;
    logic       doRead;

    // wraps for any depth, not only powers of two
    function automatic fifoPtr advance(input fifoPtr p);
        fifoPtr n;
        if (p == fifoPtr'(FIFO_DEPTH - 1)) begin
            n = '0;
        end else begin
            n = p + 1'b1;
        end
        return n;
    endfunction

    assign notEmpty    = (fill != '0);
    assign headPattern = slots[rdPtr];
    assign doRead      = take && notEmpty;

    // every item taken hands one credit back to the sampler
    assign creditReturn = doRead;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end else begin
            if (patValid) begin
                wrPtr <= advance(wrPtr);
            end
            if (doRead) begin
                rdPtr <= advance(rdPtr);
            end
            fill <= fill + creditCount'(patValid) - creditCount'(doRead);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (patValid) begin
            slots[wrPtr] <= patData;
        end
    end

endmodule

`default_nettype wire

//--- source/decisionStack.sv
`default_nettype none

module decisionStack (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             push,
    input  wire logic             replace,
    input  wire logic             pop,
    input  wire mazePkg::decision pushValue,
    input  wire logic             dump,
    output mazePkg::decision      top,
    output logic                  empty,
    output logic                  routeValid,
    output mazePkg::decision      routeDecision,
    output logic                  routeDone
);
    import mazePkg::*;

    decision   entries [STACK_DEPTH];
    stackIndex count;
    stackIndex topIdx;
    stackIndex readIdx;
    logic      full;

    assign empty  = (count == '0);
    assign full   = (count == stackIndex'(STACK_DEPTH));
    assign topIdx = count - stackIndex'(1);
    assign top    = empty ? DEC_NONE : entries[topIdx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (push && !full) begin
            count <= count + stackIndex'(1);
        end else if (pop && !empty) begin
            count <= topIdx;
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full) begin
            entries[count] <= pushValue;
        end else if (replace && !empty) begin
            entries[topIdx] <= pushValue;
        end
    end

    // route readout, bottom entry first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            readIdx    <= '0;
            routeValid <= 1'b0;
            routeDone  <= 1'b0;
        end else if (dump && !routeDone) begin
            if (readIdx == count) begin
                routeValid <= 1'b0;
                routeDone  <= 1'b1;
            end else begin
                routeValid <= 1'b1;
                readIdx    <= readIdx + stackIndex'(1);
            end
        end else begin
            routeValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dump && !routeDone && readIdx != count) begin
            routeDecision <= entries[readIdx];
        end
    end

endmodule

`default_nettype wire

//--- source/navigator.sv
`default_nettype none

module navigator (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                enable,
    input  wire logic                goal,
    input  wire logic                notEmpty,
    input  wire mazePkg::roadPattern headPattern,
    output logic                     take,
    output logic                     push,
    output logic                     replace,
    output logic                     pop,
    output mazePkg::decision         pushValue,
    input  wire mazePkg::decision    top,
    input  wire logic                empty,
    output logic                     dump,
    output mazePkg::motorCmd         motorCmd
);
    import mazePkg::*;

    navState   state;
    navState   resume;
    pauseCount pauseCnt;
    logic      moving;
    logic      junction;

    // states that consume road patterns
    assign moving = (state == NAV_FOLLOW) || (state == NAV_BACK)
                 || (state == NAV_TURN_LEFT) || (state == NAV_TURN_RIGHT);

    assign take     = enable && !goal && moving && notEmpty;
    assign junction = take && (headPattern == ROAD_JUNCTION);
    assign dump     = (state == NAV_DONE);

    // stack strobes, at most one per cycle
    always_comb begin
        push      = 1'b0;
        replace   = 1'b0;
        pop       = 1'b0;
        pushValue = DEC_NONE;
        if (junction && state == NAV_FOLLOW) begin
            push      = 1'b1;
            pushValue = DEC_LEFT;
        end else if (junction && state == NAV_BACK && !empty) begin
            case (top)
                DEC_LEFT: begin
                    replace   = 1'b1;
                    pushValue = DEC_RIGHT;
                end
                DEC_RIGHT: begin
                    replace   = 1'b1;
                    pushValue = DEC_STRAIGHT;
                end
                default: pop = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= NAV_IDLE;
            resume   <= NAV_FOLLOW;
            pauseCnt <= '0;
            motorCmd <= MOTOR_STOP;
        end else if (!enable) begin
            state    <= NAV_IDLE;
            motorCmd <= MOTOR_STOP;
        end else if (goal) begin
            state    <= NAV_DONE;
            motorCmd <= MOTOR_STOP;
        end else begin
            case (state)
                NAV_IDLE: state <= NAV_FOLLOW;
                NAV_FOLLOW: begin
                    if (take) begin
                        case (headPattern)
                            ROAD_LEFT_HARD, ROAD_LEFT_SOFT: motorCmd <= MOTOR_VEER_LEFT;
                            ROAD_RIGHT_HARD, ROAD_RIGHT_SOFT: motorCmd <= MOTOR_VEER_RIGHT;
                            ROAD_JUNCTION: begin
                                state    <= NAV_PAUSE;
                                resume   <= NAV_TURN_LEFT;
                                pauseCnt <= '0;
                                motorCmd <= MOTOR_STOP;
                            end
                            ROAD_LOST: begin
                                state    <= NAV_PAUSE;
                                resume   <= NAV_BACK;
                                pauseCnt <= '0;
                                motorCmd <= MOTOR_STOP;
                            end
                            default: motorCmd <= MOTOR_FORWARD;
                        endcase
                    end
                end
                NAV_PAUSE: begin
                    if (pauseCnt == pauseCount'(PAUSE_CYCLES - 1)) begin
                        state <= resume;
                        case (resume)
                            NAV_TURN_LEFT:  motorCmd <= MOTOR_TURN_LEFT;
                            NAV_TURN_RIGHT: motorCmd <= MOTOR_TURN_RIGHT;
                            default:        motorCmd <= MOTOR_REVERSE;
                        endcase
                    end else begin
                        pauseCnt <= pauseCnt + 1'b1;
                    end
                end
                NAV_TURN_LEFT, NAV_TURN_RIGHT: begin
                    // turn lasts until the line is centred again
                    if (take && headPattern == ROAD_STRAIGHT) begin
                        state    <= NAV_FOLLOW;
                        motorCmd <= MOTOR_FORWARD;
                    end
                end
                NAV_BACK: begin
                    if (junction) begin
                        if (empty) begin
                            state    <= NAV_DONE;
                            motorCmd <= MOTOR_STOP;
                        end else if (top == DEC_LEFT) begin
                            state    <= NAV_PAUSE;
                            resume   <= NAV_TURN_RIGHT;
                            pauseCnt <= '0;
                            motorCmd <= MOTOR_STOP;
                        end else if (top == DEC_RIGHT) begin
                            state    <= NAV_FOLLOW;
                            motorCmd <= MOTOR_FORWARD;
                        end
                        // straight entries are popped and reversing goes on
                    end
                end
                default: motorCmd <= MOTOR_STOP;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/mazeCarTop.sv
`default_nettype none

module mazeCarTop (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                enable,
    input  wire logic                goal,
    input  wire mazePkg::roadPattern sensors,
    output mazePkg::motorCmd         motorCmd,
    output logic                     routeValid,
    output mazePkg::decision         routeDecision,
    output logic                     routeDone
);
    import mazePkg::*;

    // sampler to FIFO
    logic       patValid;
    roadPattern patData;
    logic       creditReturn;

    // FIFO to navigator
    logic       notEmpty;
    roadPattern headPattern;
    logic       take;

    // navigator to stack
    logic       push;
    logic       replace;
    logic       pop;
    decision    pushValue;
    decision    stackTop;
    logic       stackEmpty;
    logic       dump;

    trackSampler sampler (
        .clk          (clk),
        .rst          (rst),
        .sensors      (sensors),
        .creditReturn (creditReturn),
        .patValid     (patValid),
        .patData      (patData)
    );

    patternFifo fifo (
        .clk          (clk),
        .rst          (rst),
        .patValid     (patValid),
        .patData      (patData),
        .take         (take),
        .notEmpty     (notEmpty),
        .headPattern  (headPattern),
        .creditReturn (creditReturn)
    );

    navigator nav (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .goal        (goal),
        .notEmpty    (notEmpty),
        .headPattern (headPattern),
        .take        (take),
        .push        (push),
        .replace     (replace),
        .pop         (pop),
        .pushValue   (pushValue),
        .top         (stackTop),
        .empty       (stackEmpty),
        .dump        (dump),
        .motorCmd    (motorCmd)
    );

    decisionStack stack (
        .clk           (clk),
        .rst           (rst),
        .push          (push),
        .replace       (replace),
        .pop           (pop),
        .pushValue     (pushValue),
        .dump          (dump),
        .top           (stackTop),
        .empty         (stackEmpty),
        .routeValid    (routeValid),
        .routeDecision (routeDecision),
        .routeDone     (routeDone)
    );

endmodule

`default_nettype wire

//--- testbench/mazeCarAsserts_asserts.sv
`default_nettype none

module mazeCarAsserts (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                patValid,
    input wire mazePkg::creditCount fill,
    input wire mazePkg::creditCount credits
);
    timeunit 1ns;
    timeprecision 1ps;

    import mazePkg::*;

    // a write into a full FIFO would overrun the head entry
    noWriteWhenFull: assert property (@(posedge clk) disable iff (rst)
        patValid |-> fill != creditCount'(FIFO_DEPTH))
        else $error("pattern written into a full FIFO");

    creditsInRange: assert property (@(posedge clk) disable iff (rst)
        credits <= creditCount'(FIFO_DEPTH))
        else $error("credit count %0d above the FIFO depth", credits);

    // every credit is held by the sampler, stored in the FIFO or riding on a write
    // so a send without credit breaks the sum
    creditsConserved: assert property (@(posedge clk) disable iff (rst)
        int'(credits) + int'(fill) + int'(patValid) == FIFO_DEPTH)
        else $error("credits %0d and FIFO fill %0d do not add up to the depth", credits, fill);

endmodule

bind mazeCarTop mazeCarAsserts checks (
    .clk      (clk),
    .rst      (rst),
    .patValid (patValid),
    .fill     (fifo.fill),
    .credits  (sampler.credits)
);

`default_nettype wire

//--- testbench/mazeCarTb.sv
`default_nettype none

module mazeCarTb;
    timeunit 1ns;
    timeprecision 1ps;

    import mazePkg::*;

    // longest wait of one step with a full pause included
    localparam int stepCycles = 2 * FILTER_LEN + PAUSE_CYCLES + 10;
    // patterns presented over all tests rounded up
    localparam int stepCount  = 36;

    logic       clk = 1'b0;
    logic       rst;
    logic       enable;
    logic       goal;
    roadPattern sensors;
    motorCmd    motor;
    logic       routeValid;
    decision    routeDecision;
    logic       routeDone;

    int      errors;
    // expected contents of the decision stack from the bottom up
    decision model[$];

    mazeCarTop uut (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .goal          (goal),
        .sensors       (sensors),
        .motorCmd      (motor),
        .routeValid    (routeValid),
        .routeDecision (routeDecision),
        .routeDone     (routeDone)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (2 * stepCount * stepCycles) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    task automatic checkMotor(input string name, input motorCmd expected, input motorCmd actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %s, got %s", name, expected.name(), actual.name());
        end
    endtask

    task automatic checkDecision(input string name, input decision expected,
                                 input decision actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %s, got %s", name, expected.name(), actual.name());
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %b, got %b", name, expected, actual);
        end
    endtask

    // long enough for the filter to pass the pattern
    task automatic holdPattern(input roadPattern pat);
        sensors = pat;
        repeat (FILTER_LEN + 2) @(negedge clk);
    endtask

    task automatic expectMotor(input string name, input motorCmd expected);
        int waited;
        waited = 0;
        while (motor !== expected && waited < stepCycles) begin
            @(negedge clk);
            waited++;
        end
        checkMotor(name, expected, motor);
    endtask

    task automatic straightOn(input string name);
        holdPattern(ROAD_STRAIGHT);
        expectMotor(name, MOTOR_FORWARD);
    endtask

    // left first at every new junction
    task automatic junctionAhead(input string name);
        holdPattern(ROAD_JUNCTION);
        model.push_back(DEC_LEFT);
        expectMotor(name, MOTOR_STOP);
        expectMotor(name, MOTOR_TURN_LEFT);
    endtask

    task automatic deadEnd(input string name);
        holdPattern(ROAD_LOST);
        expectMotor(name, MOTOR_STOP);
        expectMotor(name, MOTOR_REVERSE);
    endtask

    // reversing into a junction retries it with the next choice
    task automatic backToJunction(input string name);
        decision last;
        last = model[model.size() - 1];
        holdPattern(ROAD_JUNCTION);
        case (last)
            DEC_LEFT: begin
                model[model.size() - 1] = DEC_RIGHT;
                expectMotor(name, MOTOR_STOP);
                expectMotor(name, MOTOR_TURN_RIGHT);
            end
            DEC_RIGHT: begin
                model[model.size() - 1] = DEC_STRAIGHT;
                expectMotor(name, MOTOR_FORWARD);
            end
            default: begin
                void'(model.pop_back());
                expectMotor(name, MOTOR_REVERSE);
            end
        endcase
    endtask

    task automatic testResetIdle();
        checkMotor("reset", MOTOR_STOP, motor);
        checkBit("reset routeValid", 1'b0, routeValid);
        enable = 1'b1;
        straightOn("start");
    endtask

    task automatic testCorrection();
        holdPattern(ROAD_LEFT_HARD);
        expectMotor("correction 110", MOTOR_VEER_LEFT);
        holdPattern(ROAD_RIGHT_HARD);
        expectMotor("correction 011", MOTOR_VEER_RIGHT);
        straightOn("correction 010");
    endtask

    task automatic testJunctionAndBacktrack();
        junctionAhead("junction");
        straightOn("junction exit");
        deadEnd("dead end");
        backToJunction("backtrack");
        straightOn("backtrack exit");
    endtask

    task automatic testBackPressure();
        roadPattern burst [10];
        burst = '{ROAD_JUNCTION, ROAD_STRAIGHT, ROAD_JUNCTION, ROAD_LEFT_HARD,
                  ROAD_RIGHT_HARD, ROAD_LEFT_SOFT, ROAD_RIGHT_SOFT, ROAD_TEE,
                  ROAD_LEFT_HARD, ROAD_STRAIGHT};
        // one filter length each so patterns pile up while the car pauses
        foreach (burst[i]) begin
            sensors = burst[i];
            repeat (FILTER_LEN) @(negedge clk);
        end
        model.push_back(DEC_LEFT);
        model.push_back(DEC_LEFT);
        expectMotor("back-pressure", MOTOR_FORWARD);
        repeat (FILTER_LEN) @(negedge clk);
        checkMotor("back-pressure settled", MOTOR_FORWARD, motor);
    endtask

    task automatic testGoalReadout();
        int idx;
        int waited;
        deadEnd("route dead end 1");
        backToJunction("route left to right");
        straightOn("route exit 1");
        deadEnd("route dead end 2");
        backToJunction("route right to straight");
        deadEnd("route dead end 3");
        backToJunction("route straight popped");
        holdPattern(ROAD_LOST);
        expectMotor("route still reversing", MOTOR_REVERSE);
        backToJunction("route left to right again");
        straightOn("route exit 2");
        junctionAhead("route new junction");
        straightOn("route exit 3");
        goal = 1'b1;
        expectMotor("goal stop", MOTOR_STOP);
        idx = 0;
        waited = 0;
        while (!routeDone && waited < stepCycles + STACK_DEPTH) begin
            @(negedge clk);
            waited++;
            if (routeValid && idx < model.size()) begin
                checkDecision($sformatf("route entry %0d", idx), model[idx], routeDecision);
            end
            idx += int'(routeValid);
        end
        if (idx != model.size()) begin
            errors++;
            $display("FAILED route length: expected %0d, got %0d", model.size(), idx);
        end
        checkBit("routeDone", 1'b1, routeDone);
    endtask

    initial begin
        errors  = 0;
        rst     = 1'b1;
        enable  = 1'b0;
        goal    = 1'b0;
        sensors = ROAD_STRAIGHT;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        testResetIdle();
        testCorrection();
        testJunctionAndBacktrack();
        testBackPressure();
        testGoalReadout();
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
source/mazePkg.sv
source/trackSampler.sv
source/patternFifo.sv
source/decisionStack.sv
source/navigator.sv
source/mazeCarTop.sv
testbench/mazeCarAsserts_asserts.sv
testbench/mazeCarTb.sv

//--- run.sh
#!/bin/sh
# build and run the maze car testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module mazeCarTb -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VmazeCarTb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$log"; then
    exit 0
fi
exit 1
